// ==== lsu_pkg.sv ====
////////////////////////////////////////////////////////////
// shared constants and types for the load/store unit
// access type encoding, data word, byte enable, offsets
////////////////////////////////////////////////////////////

package lsu_pkg;

  // datapath geometry, fixed by the 32-bit instruction set
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned NumBytes    = DataWidth / 8;
  localparam int unsigned OffsetWidth = $clog2(NumBytes);  // byte offset bits in an address

  typedef logic [DataWidth-1:0]             data_t;       // one bus / register word
  typedef logic [NumBytes-1:0]              be_t;         // one enable per byte lane
  typedef logic [OffsetWidth-1:0]           offset_t;     // byte position inside a word
  typedef logic [DataWidth-OffsetWidth-1:0] word_addr_t;  // address with offset bits dropped

  // access size as decoded by the core
  // code 2'b11 is treated as a byte everywhere, same as TYPE_BYTE
  typedef enum logic [1:0] {
    TYPE_WORD = 2'b00,
    TYPE_HALF = 2'b01,
    TYPE_BYTE = 2'b10
  } lsu_type_e;

endpackage

// ==== lsu_ctx_if.sv ====
////////////////////////////////////////////////////////////
// transaction context bundle
// context registers -> load aligner
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface lsu_ctx_if;

  lsu_pkg::offset_t              offset_q;    // byte offset of the access
  lsu_pkg::lsu_type_e            type_q;      // word / half / byte
  logic                          sign_ext_q;  // sign extend loaded half or byte
  logic [lsu_pkg::DataWidth-1:8] rdata_hi_q;  // upper three bytes of the first part

  // register side drives, aligner side only reads
  modport regs (
    output offset_q,
    output type_q,
    output sign_ext_q,
    output rdata_hi_q
  );

  modport align (
    input offset_q,
    input type_q,
    input sign_ext_q,
    input rdata_hi_q
  );

endinterface

// ==== lsu_ctrl_fsm.sv ====
////////////////////////////////////////////////////////////
// bus sequencing FSM for the load/store unit
// split detection, first-part error tracking,
// context update strobes and core handshake outputs
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_ctrl_fsm (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,           // core request, held until req_done_o
  input  lsu_pkg::lsu_type_e type_i,
  input  lsu_pkg::offset_t   offset_i,
  input  logic               we_q_i,          // registered store flag
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  logic               data_err_i,
  output logic               data_req_o,
  output logic               second_part_o,   // second access of a split is on the bus
  output logic               ctrl_update_o,
  output logic               addr_update_o,
  output logic               rdata_update_o,
  output logic               req_done_o,
  output logic               resp_valid_o,
  output logic               err_o,
  output logic               busy_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,               // first part of a split waits for grant
    WAIT_RVALID_MIS,            // second part requested, first response pending
    WAIT_GNT,                   // single access or second part waits for grant
    WAIT_RVALID_MIS_GNTS_DONE   // both granted, first response still pending
  } state_e;

  state_e state_q, state_d;
  logic   split;
  logic   second_q, second_d;  // high once the first part has been granted
  logic   err_q, err_d;        // error seen on the first part

  // word off its boundary, or half word crossing into the next word
  assign split = ((type_i == lsu_pkg::TYPE_WORD) && (offset_i != '0)) ||
                 ((type_i == lsu_pkg::TYPE_HALF) && (offset_i == 2'b11));

  always_comb begin
    state_d        = state_q;
    second_d       = second_q;
    err_d          = err_q;
    data_req_o     = 1'b0;
    ctrl_update_o  = 1'b0;
    addr_update_o  = 1'b0;
    rdata_update_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          data_req_o = 1'b1;
          err_d      = 1'b0;       // fresh access, forget old first-part error
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update_o = 1'b1;
            second_d      = split;
            state_d       = split ? WAIT_RVALID_MIS : IDLE;
          end else begin
            state_d       = split ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update_o = 1'b1;
          second_d      = 1'b1;
          state_d       = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        data_req_o = 1'b1;         // second part goes out right away
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~we_q_i;  // keep first-part bytes for loads only
          addr_update_o  = data_gnt_i & ~data_err_i;
          second_d       = ~data_gnt_i;
          state_d        = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          second_d = 1'b0;
          state_d  = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update_o = ~err_q;
          second_d      = 1'b0;
          state_d       = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        if (data_rvalid_i) begin   // first response, second already granted
          err_d          = data_err_i;
          addr_update_o  = ~data_err_i;
          rdata_update_o = ~we_q_i;
          state_d        = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      second_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      state_q  <= state_d;
      second_q <= second_d;
      err_q    <= err_d;
    end
  end

  assign second_part_o = second_q;
  assign req_done_o    = (req_i | (state_q != IDLE)) & (state_d == IDLE);
  assign resp_valid_o  = data_rvalid_i & (state_q == IDLE);  // final response only
  assign err_o         = (err_q | data_err_i) & resp_valid_o;
  assign busy_o        = (state_q != IDLE);

endmodule

// ==== lsu_store_align.sv ====
////////////////////////////////////////////////////////////
// store side lane steering
// byte enables per part and write data rotation
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_store_align (
  input  lsu_pkg::lsu_type_e type_i,
  input  lsu_pkg::offset_t   offset_i,
  input  logic               second_part_i,  // enables for the upper word of a split
  input  lsu_pkg::data_t     wdata_i,
  output lsu_pkg::be_t       be_o,
  output lsu_pkg::data_t     wdata_o
);

  localparam lsu_pkg::be_t BeWord = '1;
  localparam lsu_pkg::be_t BeHalf = 4'b0011;
  localparam lsu_pkg::be_t BeByte = 4'b0001;

  ////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////

  // first part starts at the offset lane and runs up, bits past lane 3 fall off
  // second part picks up whatever was cut off, starting at lane 0
  always_comb begin
    unique case (type_i)
      lsu_pkg::TYPE_WORD: begin
        if (!second_part_i) begin
          be_o = BeWord << offset_i;      // 1111 1110 1100 1000
        end else begin
          be_o = ~(BeWord << offset_i);   // 0000 0001 0011 0111
        end
      end
      lsu_pkg::TYPE_HALF: begin
        if (!second_part_i) begin
          be_o = BeHalf << offset_i;      // offset 3 keeps lane 3 only
        end else begin
          be_o = BeByte;                  // only split case is offset 3
        end
      end
      default: be_o = BeByte << offset_i; // byte, also code 11, never split
    endcase
  end

  ////////////////////////////////////////////////////////////
  // write data rotation
  ////////////////////////////////////////////////////////////

  // rotate left by offset bytes, wrapped bytes land low for the second part
  always_comb begin
    unique case (offset_i)
      2'b00:   wdata_o = wdata_i;
      2'b01:   wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'b10:   wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

endmodule

// ==== lsu_txn_regs.sv ====
////////////////////////////////////////////////////////////
// transaction context and first-part read data registers
// plus word address generation for both parts
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_txn_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               ctrl_update_i,   // latch type / offset / direction
  input  logic               addr_update_i,   // latch word address
  input  logic               rdata_update_i,  // latch first-part load data
  input  logic               second_part_i,
  input  lsu_pkg::lsu_type_e type_i,
  input  lsu_pkg::offset_t   offset_i,
  input  logic               sign_ext_i,
  input  logic               we_i,
  input  logic [31:0]        addr_i,
  input  lsu_pkg::data_t     data_rdata_i,
  output logic               we_q_o,
  output logic [31:0]        data_addr_o,
  lsu_ctx_if.regs            ctx
);

  lsu_pkg::word_addr_t word_addr_q;
  lsu_pkg::word_addr_t word_addr_next;  // following word for the second part

  // context steering the aligner and the error direction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctx.offset_q   <= '0;
      ctx.type_q     <= lsu_pkg::TYPE_WORD;
      ctx.sign_ext_q <= 1'b0;
      we_q_o         <= 1'b0;
    end else if (ctrl_update_i) begin
      ctx.offset_q   <= offset_i;
      ctx.type_q     <= type_i;
      ctx.sign_ext_q <= sign_ext_i;
      we_q_o         <= we_i;
    end
  end

  // payload, only meaningful once the matching strobe has fired
  always_ff @(posedge clk_i) begin
    if (addr_update_i) begin
      word_addr_q <= addr_i[lsu_pkg::DataWidth-1:lsu_pkg::OffsetWidth];
    end
    if (rdata_update_i) begin
      ctx.rdata_hi_q <= data_rdata_i[lsu_pkg::DataWidth-1:8];  // byte 0 never needed
    end
  end

  assign word_addr_next = word_addr_q + 1'b1;

  // first part straight from the core, second from the latched copy
  assign data_addr_o = second_part_i ?
                       {word_addr_next, 2'b00} :
                       {addr_i[lsu_pkg::DataWidth-1:lsu_pkg::OffsetWidth], 2'b00};

endmodule

// ==== lsu_load_align.sv ====
////////////////////////////////////////////////////////////
// load data realignment
// split word merge, half / byte select, sign extension
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_load_align (
  input  lsu_pkg::data_t data_rdata_i,  // current bus response
  lsu_ctx_if.align       ctx,
  output lsu_pkg::data_t rdata_o
);

  lsu_pkg::data_t rdata_w;   // word, merged across parts when split
  logic [15:0]    rdata_h;   // raw half word at the offset
  logic [7:0]     rdata_b;   // raw byte at the offset

  // low bytes come from the first part, high bytes from this response
  always_comb begin
    unique case (ctx.offset_q)
      2'b00:   rdata_w = data_rdata_i;
      2'b01:   rdata_w = {data_rdata_i[7:0],  ctx.rdata_hi_q[31:8]};
      2'b10:   rdata_w = {data_rdata_i[15:0], ctx.rdata_hi_q[31:16]};
      default: rdata_w = {data_rdata_i[23:0], ctx.rdata_hi_q[31:24]};
    endcase
  end

  always_comb begin
    unique case (ctx.offset_q)
      2'b00:   rdata_h = data_rdata_i[15:0];
      2'b01:   rdata_h = data_rdata_i[23:8];
      2'b10:   rdata_h = data_rdata_i[31:16];
      default: rdata_h = {data_rdata_i[7:0], ctx.rdata_hi_q[31:24]};  // crosses the word
    endcase
  end

  always_comb begin
    unique case (ctx.offset_q)
      2'b00:   rdata_b = data_rdata_i[7:0];
      2'b01:   rdata_b = data_rdata_i[15:8];
      2'b10:   rdata_b = data_rdata_i[23:16];
      default: rdata_b = data_rdata_i[31:24];
    endcase
  end

  ////////////////////////////////////////////////////////////
  // size select and extension
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (ctx.type_q)
      lsu_pkg::TYPE_WORD: rdata_o = rdata_w;
      lsu_pkg::TYPE_HALF: rdata_o = {{16{ctx.sign_ext_q & rdata_h[15]}}, rdata_h};
      default:            rdata_o = {{24{ctx.sign_ext_q & rdata_b[7]}}, rdata_b};  // byte
    endcase
  end

endmodule

// ==== lsu_top.sv ====
////////////////////////////////////////////////////////////
// load/store unit top level
// core and bus ports, FSM, aligners, context registers
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // core side
  input  logic                req_i,
  input  logic                we_i,
  input  logic [1:0]          type_i,        // 00 word, 01 half, 1x byte
  input  logic                sign_ext_i,
  input  logic [31:0]         addr_i,
  input  lsu_pkg::data_t      wdata_i,
  output logic                req_done_o,
  output logic                resp_valid_o,
  output lsu_pkg::data_t      rdata_o,
  output logic                rdata_valid_o,
  output logic                load_err_o,
  output logic                store_err_o,
  output logic                busy_o,
  // data bus side
  output logic                data_req_o,
  input  logic                data_gnt_i,
  output logic [31:0]         data_addr_o,   // always word aligned
  output logic                data_we_o,
  output lsu_pkg::be_t        data_be_o,
  output lsu_pkg::data_t      data_wdata_o,
  input  logic                data_rvalid_i,
  input  logic                data_err_i,
  input  lsu_pkg::data_t      data_rdata_i
);

  lsu_pkg::lsu_type_e type_e;
  lsu_pkg::offset_t   offset;
  logic               ctrl_update, addr_update, rdata_update;
  logic               second_part;
  logic               we_q;
  logic               resp_valid;
  logic               err;                   // already qualified by resp_valid

  lsu_ctx_if ctx_if ();

  assign type_e = lsu_pkg::lsu_type_e'(type_i);
  assign offset = addr_i[lsu_pkg::OffsetWidth-1:0];

  lsu_ctrl_fsm i_ctrl_fsm (
    .clk_i, .rst_ni, .req_i,
    .type_i         (type_e),
    .offset_i       (offset),
    .we_q_i         (we_q),
    .data_gnt_i, .data_rvalid_i, .data_err_i, .data_req_o,
    .second_part_o  (second_part),
    .ctrl_update_o  (ctrl_update),
    .addr_update_o  (addr_update),
    .rdata_update_o (rdata_update),
    .req_done_o,
    .resp_valid_o   (resp_valid),
    .err_o          (err),
    .busy_o
  );

  lsu_store_align i_store_align (
    .type_i        (type_e),
    .offset_i      (offset),
    .second_part_i (second_part),
    .wdata_i,
    .be_o          (data_be_o),
    .wdata_o       (data_wdata_o)
  );

  lsu_txn_regs i_txn_regs (
    .clk_i, .rst_ni,
    .ctrl_update_i  (ctrl_update),
    .addr_update_i  (addr_update),
    .rdata_update_i (rdata_update),
    .second_part_i  (second_part),
    .type_i         (type_e),
    .offset_i       (offset),
    .sign_ext_i, .we_i, .addr_i, .data_rdata_i,
    .we_q_o         (we_q),
    .data_addr_o,
    .ctx            (ctx_if)
  );

  lsu_load_align i_load_align (
    .data_rdata_i,
    .ctx     (ctx_if),
    .rdata_o
  );

  // response steering by the latched direction
  assign resp_valid_o  = resp_valid;
  assign rdata_valid_o = resp_valid & ~we_q;
  assign load_err_o    = err & ~we_q;
  assign store_err_o   = err & we_q;
  assign data_we_o     = we_i;

endmodule

// ==== tb_lsu_top.sv ====
////////////////////////////////////////////////////////////
// testbench for the load/store unit top level
// bus memory model with random delays and errors,
// load reference, response checker and watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_lsu_top;

  localparam int          ClkPeriod = 40;
  localparam int          MemBytes  = 64;             // 16 words behind the bus
  localparam logic [31:0] Base      = 32'h0000_2000;  // first byte of the model
  localparam int          NumDir    = 36;             // 3 types x 4 offsets x 3 accesses
  localparam int          NumRand   = 300;
  localparam int          NumTxn    = NumDir + NumRand;

  logic        clk_i, rst_ni;
  logic        req_i, we_i, sign_ext_i;
  logic [1:0]  type_i;
  logic [31:0] addr_i, wdata_i, rdata_o;
  logic        req_done_o, resp_valid_o, rdata_valid_o, load_err_o, store_err_o, busy_o;
  logic        data_req_o, data_gnt_i, data_we_o, data_rvalid_i, data_err_i;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;
  logic [3:0]  data_be_o;

  integer      seed = 62163;
  int          errors = 0;
  int          txn_no = 0;
  string       phase = "reset";
  logic [7:0]  mem [MemBytes];     // bus side storage
  logic [7:0]  shadow [MemBytes];  // what the core expects to read back
  bit          known [MemBytes];   // cleared by an erroring store
  logic        inj_err;            // some part of the current access got an error
  int          part_cnt, resp_cnt;
  logic        cur_we, cur_sext;
  logic [1:0]  cur_type;
  logic [31:0] cur_addr, cur_wdata;

  lsu_top i_lsu_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s txn %0d %s: expected 0x%08h, actual 0x%08h",
               phase, txn_no, name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic int size_of(input logic [1:0] t);
    return (t == 2'b00) ? 4 : (t == 2'b01) ? 2 : 1;  // 11 counts as a byte
  endfunction

  // little endian assembly from the shadow followed by extension
  function automatic logic [31:0] ref_load(input logic [31:0] a, input logic [1:0] t,
                                           input logic s);
    logic [31:0] v;
    int          n;
    int          off;
    v   = '0;
    n   = size_of(t);
    off = int'(a - Base);
    for (int k = 0; k < n; k++) begin
      v[8*k +: 8] = shadow[off + k];
    end
    if (s && (n < 4) && v[8*n-1]) begin
      for (int k = n; k < 4; k++) begin
        v[8*k +: 8] = 8'hff;
      end
    end
    return v;
  endfunction

  function automatic bit all_known(input logic [31:0] a, input logic [1:0] t);
    int off;
    bit ok;
    off = int'(a - Base);
    ok  = 1'b1;
    for (int k = 0; k < size_of(t); k++) begin
      ok &= known[off + k];
    end
    return ok;
  endfunction

  // lanes of the bytes that fall into word (a >> 2) + p
  function automatic logic [3:0] exp_be(input logic [31:0] a, input logic [1:0] t, input int p);
    logic [3:0]  be;
    logic [31:0] b;
    be = '0;
    for (int k = 0; k < size_of(t); k++) begin
      b = a + 32'(k);
      if ((b >> 2) == ((a >> 2) + 32'(p))) begin
        be[b[1:0]] = 1'b1;
      end
    end
    return be;
  endfunction

  // check one granted part against byte address arithmetic
  task automatic check_access();
    logic [31:0] exp_adr;
    logic [3:0]  be;
    int          k;
    exp_adr = ((cur_addr >> 2) + 32'(part_cnt)) << 2;
    be      = exp_be(cur_addr, cur_type, part_cnt);
    check_value("bus address", exp_adr, data_addr_o);
    check_value("byte enable", be, data_be_o);
    check_value("write enable", cur_we, data_we_o);
    for (int l = 0; l < 4; l++) begin
      k = int'(exp_adr) + l - int'(cur_addr);  // store byte that belongs on lane l
      if (cur_we && be[l]) begin
        check_value("store lane", cur_wdata[8*k +: 8], data_wdata_o[8*l +: 8]);
      end
    end
    part_cnt++;
  endtask

  ////////////////////////////////////////////////////////////
  // bus memory model sampled at the falling edge
  ////////////////////////////////////////////////////////////

  initial begin
    int          w;
    int          due;
    int          cyc;
    int          gnt_wait;           // cycles left before the next grant
    logic        err, hold_pend, hold_we, nxt_gnt, nxt_rv, nxt_err;
    logic [3:0]  hold_be;
    logic [31:0] hold_addr, hold_wdata, nxt_data;
    logic [31:0] rq_data [$];        // in-order response queue
    logic        rq_err [$];
    int          rq_due [$];
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = '0;
    hold_pend     = 1'b0;
    nxt_data      = '0;
    cyc           = 0;
    gnt_wait      = {$random(seed)} % 4;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      cyc++;
      if (hold_pend) begin           // request not granted last cycle must not move
        check_value("request held", {hold_be, hold_we, 1'b1}, {data_be_o, data_we_o, data_req_o});
        check_value("address held", hold_addr, data_addr_o);
        check_value("wdata held", hold_wdata, data_wdata_o);
        check_value("busy while held", 1'b1, busy_o);  // unit is waiting on the bus
      end
      hold_pend  = data_req_o && !data_gnt_i;
      hold_addr  = data_addr_o;
      hold_be    = data_be_o;
      hold_we    = data_we_o;
      hold_wdata = data_wdata_o;
      if (data_req_o && data_gnt_i) begin
        check_access();
        err     = ({$random(seed)} % 8) == 0;  // about one part in eight
        inj_err = inj_err | err;
        w       = int'(data_addr_o - Base);
        if ((w < 0) || (w > MemBytes - 4)) begin
          errors++;
          $display("bus access outside the memory model at 0x%08h", data_addr_o);
          w = 0;
        end else if (data_we_o && !err) begin
          for (int l = 0; l < 4; l++) begin
            if (data_be_o[l]) mem[w + l] = data_wdata_o[8*l +: 8];
          end
        end
        due = cyc + 1 + ({$random(seed)} % 3);
        if ((rq_due.size() > 0) && (due <= rq_due[$])) due = rq_due[$] + 1;
        rq_data.push_back({mem[w+3], mem[w+2], mem[w+1], mem[w]});
        rq_err.push_back(err);
        rq_due.push_back(due);
        gnt_wait = {$random(seed)} % 4;
      end else if (data_req_o && (gnt_wait > 0)) begin
        gnt_wait--;
      end
      nxt_gnt = (gnt_wait == 0);     // may be offered before the request shows up
      nxt_rv  = 1'b0;
      nxt_err = 1'b0;
      if ((rq_due.size() > 0) && (rq_due[0] <= cyc + 1)) begin
        nxt_rv   = 1'b1;
        nxt_data = rq_data.pop_front();
        nxt_err  = rq_err.pop_front();
        due      = rq_due.pop_front();
      end
      @(posedge clk_i);
      #2;
      data_gnt_i    = nxt_gnt;
      data_rvalid_i = nxt_rv;
      data_err_i    = nxt_err;
      data_rdata_i  = nxt_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // response checker
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni && resp_valid_o) begin
      resp_cnt++;
      check_value("load error", !cur_we && inj_err, load_err_o);
      check_value("store error", cur_we && inj_err, store_err_o);
      check_value("rdata valid", !cur_we, rdata_valid_o);
      if (!cur_we && !inj_err && all_known(cur_addr, cur_type)) begin
        check_value("load data", ref_load(cur_addr, cur_type, cur_sext), rdata_o);
      end
    end else if (rst_ni) begin
      check_value("error without response", 2'b00, {load_err_o, store_err_o});
    end
  end

  // drive one core access until req_done_o and wait for its response
  task automatic run_txn(input logic we, input logic [1:0] t, input logic s,
                         input logic [31:0] a, input logic [31:0] wd);
    int off;
    int parts;
    @(posedge clk_i);
    #2;
    txn_no++;
    {cur_we, cur_type, cur_sext, cur_addr, cur_wdata} = {we, t, s, a, wd};
    inj_err    = 1'b0;
    part_cnt   = 0;
    resp_cnt   = 0;
    req_i      = 1'b1;
    we_i       = we;
    type_i     = t;
    sign_ext_i = s;
    addr_i     = a;
    wdata_i    = wd;
    parts      = ((a[1:0] + size_of(t)) > 4) ? 2 : 1;  // bytes past lane 3 spill into N+1
    @(negedge clk_i);
    while (!req_done_o) @(negedge clk_i);
    @(posedge clk_i);
    #2;
    req_i = 1'b0;
    check_value("grants at request done", parts, part_cnt);  // every part granted by now
    while (resp_cnt == 0) @(posedge clk_i);
    @(posedge clk_i);                // a late extra response would show here
    check_value("bus accesses", parts, part_cnt);
    check_value("responses", 1, resp_cnt);
    if (we) begin
      off = int'(a - Base);
      for (int k = 0; k < size_of(t); k++) begin
        shadow[off + k] = wd[8*k +: 8];
        known[off + k]  = !inj_err;  // erroring store leaves these bytes open
      end
    end
  endtask

  initial begin
    logic [31:0] a, wd, r;
    {req_i, we_i, sign_ext_i, type_i} = '0;
    addr_i  = Base;
    wdata_i = '0;
    rst_ni  = 1'b0;
    inj_err = 1'b0;
    for (int i = 0; i < MemBytes; i++) begin
      mem[i]    = 8'(i * 37) ^ 8'h5a;  // distinct byte per address
      shadow[i] = mem[i];
      known[i]  = 1'b1;
    end
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    check_value("outputs after reset", 6'b0,
                {data_req_o, req_done_o, resp_valid_o, load_err_o, store_err_o, busy_o});

    phase = "directed";              // each store is followed by a zero and a sign extended load
    for (int t = 0; t < 3; t++) begin
      for (int o = 0; o < 4; o++) begin
        a  = Base + 32'(12 * t + 4 + o);
        wd = $random(seed);
        if (o % 2 == 1) wd = wd | 32'h8080_8080;  // force negative halves and bytes
        run_txn(1'b1, 2'(t), 1'b0, a, wd);
        run_txn(1'b0, 2'(t), 1'b0, a, '0);
        run_txn(1'b0, 2'(t), 1'b1, a, '0);
      end
    end

    phase = "random";
    repeat (NumRand) begin
      r  = $random(seed);
      a  = Base + ({$random(seed)} % 60);  // leaves room for a split at the top
      wd = $random(seed);
      run_txn(r[0], r[2:1], r[3], a, wd);
    end

    $display("errors: %0d in %0d transactions", errors, txn_no);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // worst case split with every delay at maximum stays under 16 cycles
  initial begin
    #(ClkPeriod * (NumTxn * 2 * 8 + 10));
    $display("timeout: no response");
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== compile.f ====
lsu_pkg.sv
lsu_ctx_if.sv
lsu_ctrl_fsm.sv
lsu_store_align.sv
lsu_txn_regs.sv
lsu_load_align.sv
lsu_top.sv
tb_lsu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_lsu_top -f compile.f --Mdir obj_dir -o sim_lsu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -Fxq "** PASS **" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
